//--- meta_vectors.txt
# R name type_hex taken sp lhp ghp repeat
# L name type_hex sp lhp_beq lhp_bne lhp_blt lhp_bge lhp_bltu lhp_bgeu ghp exp_taken exp_source
L reset_tie_beq 20 0 0 0 0 0 0 0 3 1 2
L reset_tie_bne 10 1 0 0 0 0 0 0 1 0 2
R sp_train_blt 08 1 1 0 0 3
L sp_wins_blt 08 1 0 0 0 0 0 0 0 1 0
L ghp_still_bge 04 1 0 0 0 0 0 0 2 1 2
R lhp_train_bltu 02 1 0 3 1 2
L lhp_sel_bltu 02 0 0 0 0 0 3 0 1 1 1
L lhp_sel_other 02 0 3 3 3 3 0 3 1 0 2
R sat_sp_ghp 01 0 0 2 1 62
R sat_ghp_only 01 0 1 2 1 8
L sat_ghp_wins 01 0 0 0 0 0 0 2 1 0 2
L sat_other_row 20 0 0 0 0 0 0 0 0 0 2
R sat_ghp_miss 01 1 1 2 1 1
L sat_cleared 01 0 0 0 0 0 0 2 1 0 0
L b2b_blt 08 1 0 0 0 0 0 0 0 1 0
L fwd_bne 10 0 0 0 0 0 0 0 3 0 0
R fwd_update 10 0 0 2 3 1
L fwd_after 10 0 0 0 0 0 0 0 3 0 0
R end_bge 04 1 1 3 3 1

//--- files.f
branch_pkg.sv
chooser_pkg.sv
branch_type_decoder.sv
accuracy_table.sv
meta_arbiter.sv
meta_predictor.sv
meta_predictor_asserts.sv
tb_meta_predictor.sv

//--- Bender.yml
package:
  name: meta_predictor

sources:
  - branch_pkg.sv
  - chooser_pkg.sv
  - branch_type_decoder.sv
  - accuracy_table.sv
  - meta_arbiter.sv
  - meta_predictor.sv
  - target: test
    files:
      - meta_predictor_asserts.sv
      - tb_meta_predictor.sv

//--- tb_meta_predictor.sv
`timescale 1ns/1ps

module tb_meta_predictor;

  import branch_pkg::*;
  import chooser_pkg::*;

  localparam int                    COUNT_WIDTH     = DEFAULT_COUNT_WIDTH;
  localparam int                    STAT_WIDTH      = DEFAULT_STAT_WIDTH;
  localparam int                    STAT_CLEAR_BITS = 2;
  localparam logic [STAT_WIDTH-1:0] STAT_INIT       = '0;
  localparam int                    STAT_MAX        = (1 << STAT_WIDTH) - 1;
  localparam int                    LOCAL_ENTRIES   = 1 << COUNT_WIDTH;
  localparam int                    RANDOM_OPS      = 200;

  typedef logic [COUNT_WIDTH-1:0]                  count_t;
  typedef logic [NUM_BRANCH_TYPES*COUNT_WIDTH-1:0] bank_t;

  // One issued lookup or resolve operation
  typedef struct packed {
    logic           lookup;
    logic           from_file;
    branch_onehot_t typ;
    logic           sp;
    logic           taken;
    count_t         lhp;
    count_t         ghp;
    bank_t          bank;
    logic           exp_taken;
    source_t        exp_src;
  } op_t;

  logic           clk;
  logic           rst_n;
  logic           lookup_valid;
  branch_onehot_t lookup_type;
  logic           lookup_sp;
  count_t         lookup_ghp;
  bank_t          lookup_lhp_bank;
  logic           resolve_valid;
  branch_onehot_t resolve_type;
  logic           resolve_taken;
  logic           resolve_sp;
  count_t         resolve_lhp;
  count_t         resolve_ghp;
  logic           prediction_valid;
  logic           prediction_taken;
  source_t        prediction_source;

  op_t         ops [$];
  string       names [$];
  int          due_q [$];
  int          idx_q [$];
  logic        exp_taken_q [$];
  source_t     exp_src_q [$];
  int          sp_model [NUM_BRANCH_TYPES][2];
  int          lhp_model [NUM_BRANCH_TYPES][LOCAL_ENTRIES];
  int          ghp_model [NUM_BRANCH_TYPES][LOCAL_ENTRIES];
  logic [31:0] lcg_state = 32'hafaf_4dac;
  int          vector_count;
  int          cycle_limit = 1000;

  meta_predictor #(
    .COUNT_WIDTH     (COUNT_WIDTH),
    .STAT_WIDTH      (STAT_WIDTH),
    .STAT_CLEAR_BITS (STAT_CLEAR_BITS),
    .STAT_INIT       (STAT_INIT)
  ) u_meta_predictor (
    .clk               (clk),
    .rst_n             (rst_n),
    .lookup_valid      (lookup_valid),
    .lookup_type       (lookup_type),
    .lookup_sp         (lookup_sp),
    .lookup_ghp        (lookup_ghp),
    .lookup_lhp_bank   (lookup_lhp_bank),
    .resolve_valid     (resolve_valid),
    .resolve_type      (resolve_type),
    .resolve_taken     (resolve_taken),
    .resolve_sp        (resolve_sp),
    .resolve_lhp       (resolve_lhp),
    .resolve_ghp       (resolve_ghp),
    .prediction_valid  (prediction_valid),
    .prediction_taken  (prediction_taken),
    .prediction_source (prediction_source)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // Bit i of the one-hot type is table row i
  function automatic int row_of(branch_onehot_t t);
    int row;
    row = 0;
    for (int i = 0; i < NUM_BRANCH_TYPES; i++)
    begin
      if (t[i])
      begin
        row = i;
      end
    end
    return row;
  endfunction

  function automatic int updated_stat(int cur, logic hit);
    int result;
    if (hit)
    begin
      result = (cur == STAT_MAX) ? cur : cur + 1;
    end
    else
    begin
      result = (cur >> STAT_CLEAR_BITS) << STAT_CLEAR_BITS;
    end
    return result;
  endfunction

  task automatic apply_resolve(op_t op);
    int row;
    row = row_of(op.typ);
    sp_model[row][op.sp] = updated_stat(sp_model[row][op.sp], op.sp == op.taken);
    lhp_model[row][op.lhp] = updated_stat(lhp_model[row][op.lhp],
                                          op.lhp[COUNT_WIDTH-1] == op.taken);
    ghp_model[row][op.ghp] = updated_stat(ghp_model[row][op.ghp],
                                          op.ghp[COUNT_WIDTH-1] == op.taken);
  endtask

  task automatic fail_run(string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "run stopped");
  endtask

  task automatic load_vectors();
    int    fd;
    int    n;
    int    typ, taken, sp, lhp, ghp, count;
    int    l5, l4, l3, l2, l1, l0, exp_t, exp_s;
    string line, kind, name;
    op_t   op;
    fd = $fopen("meta_vectors.txt", "r");
    if (fd == 0)
    begin
      fail_run("could not open meta_vectors.txt");
    end
    while ($fgets(line, fd) > 0)
    begin
      kind = "";
      n = $sscanf(line, "%s", kind);
      op = '0;
      op.from_file = 1'b1;
      if (kind == "R")
      begin
        n = $sscanf(line, "%s %s %h %d %d %d %d %d", kind, name, typ, taken, sp, lhp, ghp,
                    count);
        if (n != 8)
        begin
          fail_run({"malformed resolve line: ", line});
        end
        op.typ   = branch_onehot_t'(typ);
        op.taken = taken[0];
        op.sp    = sp[0];
        op.lhp   = count_t'(lhp);
        op.ghp   = count_t'(ghp);
        repeat (count)
        begin
          ops.push_back(op);
          names.push_back(name);
        end
      end
      else if (kind == "L")
      begin
        n = $sscanf(line, "%s %s %h %d %d %d %d %d %d %d %d %d %d", kind, name, typ, sp,
                    l5, l4, l3, l2, l1, l0, ghp, exp_t, exp_s);
        if (n != 13)
        begin
          fail_run({"malformed lookup line: ", line});
        end
        op.lookup    = 1'b1;
        op.typ       = branch_onehot_t'(typ);
        op.sp        = sp[0];
        op.ghp       = count_t'(ghp);
        op.bank      = {count_t'(l5), count_t'(l4), count_t'(l3),
                        count_t'(l2), count_t'(l1), count_t'(l0)};
        op.exp_taken = exp_t[0];
        op.exp_src   = source_t'(exp_s);
        ops.push_back(op);
        names.push_back(name);
      end
    end
    $fclose(fd);
  endtask

  task automatic add_random_ops();
    op_t         op;
    logic [31:0] r;
    for (int i = 0; i < RANDOM_OPS; i++)
    begin
      r = next_random();
      op = '0;
      op.lookup = r[31];
      op.typ    = branch_onehot_t'(1) << (r[30:16] % NUM_BRANCH_TYPES);
      op.sp     = r[15];
      op.taken  = r[14];
      op.lhp    = count_t'(r >> 4);
      op.ghp    = count_t'(r >> 8);
      op.bank   = bank_t'(next_random());
      ops.push_back(op);
      names.push_back($sformatf("random_%0d", i));
    end
  endtask

  task automatic drive_op(int k);
    op_t op;
    if (k < ops.size())
    begin
      op = ops[k];
      lookup_valid  <= op.lookup;
      resolve_valid <= !op.lookup;
      if (op.lookup)
      begin
        lookup_type     <= op.typ;
        lookup_sp       <= op.sp;
        lookup_ghp      <= op.ghp;
        lookup_lhp_bank <= op.bank;
      end
      else
      begin
        resolve_type  <= op.typ;
        resolve_taken <= op.taken;
        resolve_sp    <= op.sp;
        resolve_lhp   <= op.lhp;
        resolve_ghp   <= op.ghp;
        apply_resolve(op);
      end
    end
    else
    begin
      lookup_valid  <= 1'b0;
      resolve_valid <= 1'b0;
    end
  endtask

  // Highest accuracy wins and a tie goes to GHP before LHP before SP
  task automatic queue_expected(int idx, int due);
    op_t     op;
    int      row;
    count_t  lhp;
    int      sp_acc, lhp_acc, ghp_acc;
    logic    taken;
    source_t src;
    op      = ops[idx];
    row     = row_of(op.typ);
    lhp     = op.bank[row*COUNT_WIDTH +: COUNT_WIDTH];
    sp_acc  = sp_model[row][op.sp];
    lhp_acc = lhp_model[row][lhp];
    ghp_acc = ghp_model[row][op.ghp];
    if (ghp_acc >= lhp_acc && ghp_acc >= sp_acc)
    begin
      taken = op.ghp[COUNT_WIDTH-1];
      src   = SRC_GHP;
    end
    else if (lhp_acc >= sp_acc)
    begin
      taken = lhp[COUNT_WIDTH-1];
      src   = SRC_LHP;
    end
    else
    begin
      taken = op.sp;
      src   = SRC_SP;
    end
    if (op.from_file)
    begin
      taken = op.exp_taken;
      src   = op.exp_src;
    end
    due_q.push_back(due);
    idx_q.push_back(idx);
    exp_taken_q.push_back(taken);
    exp_src_q.push_back(src);
  endtask

  task automatic compare_taken(string name, logic expected, logic actual);
    if (actual !== expected)
    begin
      $display("FAIL %s: taken expected %0b actual %0b", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "taken mismatch");
    end
  endtask

  task automatic check_source(string name, source_t expected, source_t actual);
    if (actual !== expected)
    begin
      $display("FAIL %s: source expected %0d actual %0d", name, expected, actual);
      $display("Verification failed");
      $fatal(1, "source mismatch");
    end
  endtask

  task automatic check_prediction(int cyc);
    if (prediction_valid === 1'b1)
    begin
      if (due_q.size() == 0 || due_q[0] != cyc)
      begin
        fail_run($sformatf("prediction_valid high in cycle %0d with no lookup due", cyc));
      end
      else
      begin
        compare_taken(names[idx_q[0]], exp_taken_q[0], prediction_taken);
        check_source(names[idx_q[0]], exp_src_q[0], prediction_source);
        void'(due_q.pop_front());
        void'(idx_q.pop_front());
        void'(exp_taken_q.pop_front());
        void'(exp_src_q.pop_front());
      end
    end
    else if (due_q.size() > 0 && due_q[0] == cyc)
    begin
      fail_run({"no prediction two cycles after lookup ", names[idx_q[0]]});
    end
  endtask

  initial
  begin
    int k;
    rst_n           = 1'b0;
    lookup_valid    = 1'b0;
    lookup_type     = '0;
    lookup_sp       = 1'b0;
    lookup_ghp      = '0;
    lookup_lhp_bank = '0;
    resolve_valid   = 1'b0;
    resolve_type    = '0;
    resolve_taken   = 1'b0;
    resolve_sp      = 1'b0;
    resolve_lhp     = '0;
    resolve_ghp     = '0;
    for (int r = 0; r < NUM_BRANCH_TYPES; r++)
    begin
      sp_model[r] = '{int'(STAT_INIT), int'(STAT_INIT)};
      for (int e = 0; e < LOCAL_ENTRIES; e++)
      begin
        lhp_model[r][e] = int'(STAT_INIT);
        ghp_model[r][e] = int'(STAT_INIT);
      end
    end
    load_vectors();
    vector_count = ops.size();
    add_random_ops();
    cycle_limit = 2 * vector_count + RANDOM_OPS + 50;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    k = 0;
    while (k <= ops.size() || due_q.size() > 0)
    begin
      @(posedge clk);
      drive_op(k);
      // A resolve in the cycle after a lookup still reaches it
      if (k > 0 && k <= ops.size() && ops[k-1].lookup)
      begin
        queue_expected(k - 1, k + 1);
      end
      @(negedge clk);
      check_prediction(k);
      if (u_meta_predictor.u_asserts.violations != 0)
      begin
        fail_run($sformatf("a bound assertion on the DUT ports failed by cycle %0d", k));
      end
      k++;
    end
    $display("Verification passed");
    $finish;
  end

  initial
  begin
    int cycles;
    cycles = 0;
    wait (rst_n === 1'b1);
    while (cycles <= cycle_limit)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Verification failed");
    $fatal(1, "timeout");
  end

endmodule

//--- meta_predictor_asserts.sv
`timescale 1ns/1ps

module meta_predictor_asserts (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       lookup_valid,
  input branch_pkg::branch_onehot_t lookup_type,
  input logic                       resolve_valid,
  input branch_pkg::branch_onehot_t resolve_type,
  input logic                       prediction_valid
);

  int violations = 0;

  lookup_type_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    lookup_valid |-> $onehot(lookup_type))
  else
  begin
    $error("lookup_type is not one-hot while lookup_valid is high");
    violations++;
  end

  resolve_type_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    resolve_valid |-> $onehot(resolve_type))
  else
  begin
    $error("resolve_type is not one-hot while resolve_valid is high");
    violations++;
  end

  // Fixed two-cycle latency from lookup to prediction
  no_lookup_no_prediction: assert property (@(posedge clk) disable iff (!rst_n)
    !lookup_valid |-> ##2 !prediction_valid)
  else
  begin
    $error("prediction_valid high two cycles after a cycle without lookup");
    violations++;
  end

  reset_clears_prediction: assert property (@(posedge clk)
    !rst_n |=> !prediction_valid)
  else
  begin
    $error("prediction_valid high during reset");
    violations++;
  end

endmodule

bind meta_predictor meta_predictor_asserts u_asserts (
  .clk              (clk),
  .rst_n            (rst_n),
  .lookup_valid     (lookup_valid),
  .lookup_type      (lookup_type),
  .resolve_valid    (resolve_valid),
  .resolve_type     (resolve_type),
  .prediction_valid (prediction_valid)
);

//--- meta_predictor.sv
`timescale 1ns/1ps

module meta_predictor #(
  parameter int                    COUNT_WIDTH     = chooser_pkg::DEFAULT_COUNT_WIDTH,
  parameter int                    STAT_WIDTH      = chooser_pkg::DEFAULT_STAT_WIDTH,
  parameter int                    STAT_CLEAR_BITS = 2,
  parameter logic [STAT_WIDTH-1:0] STAT_INIT       = '0
) (
  input  logic                                                clk,
  input  logic                                                rst_n,
  input  logic                                                lookup_valid,
  input  branch_pkg::branch_onehot_t                          lookup_type,
  input  logic                                                lookup_sp,
  input  logic [COUNT_WIDTH-1:0]                              lookup_ghp,
  input  logic [branch_pkg::NUM_BRANCH_TYPES*COUNT_WIDTH-1:0] lookup_lhp_bank,
  input  logic                                                resolve_valid,
  input  branch_pkg::branch_onehot_t                          resolve_type,
  input  logic                                                resolve_taken,
  input  logic                                                resolve_sp,
  input  logic [COUNT_WIDTH-1:0]                              resolve_lhp,
  input  logic [COUNT_WIDTH-1:0]                              resolve_ghp,
  output logic                                                prediction_valid,
  output logic                                                prediction_taken,
  output chooser_pkg::source_t                                prediction_source
);

  import branch_pkg::*;

  logic                   s1_valid;
  logic                   s1_sp;
  branch_addr_t           s1_addr;
  branch_addr_t           update_addr;
  logic [COUNT_WIDTH-1:0] s1_ghp;
  logic [COUNT_WIDTH-1:0] s1_lhp;
  logic [STAT_WIDTH-1:0]  sp_stat;
  logic [STAT_WIDTH-1:0]  lhp_stat;
  logic [STAT_WIDTH-1:0]  ghp_stat;

  branch_type_decoder #(
    .COUNT_WIDTH (COUNT_WIDTH)
  ) u_decoder (
    .clk             (clk),
    .rst_n           (rst_n),
    .lookup_valid    (lookup_valid),
    .lookup_type     (lookup_type),
    .lookup_sp       (lookup_sp),
    .lookup_ghp      (lookup_ghp),
    .lookup_lhp_bank (lookup_lhp_bank),
    .resolve_type    (resolve_type),
    .s1_valid        (s1_valid),
    .s1_sp           (s1_sp),
    .s1_addr         (s1_addr),
    .s1_ghp          (s1_ghp),
    .s1_lhp          (s1_lhp),
    .update_addr     (update_addr)
  );

  accuracy_table #(
    .COUNT_WIDTH     (COUNT_WIDTH),
    .STAT_WIDTH      (STAT_WIDTH),
    .STAT_CLEAR_BITS (STAT_CLEAR_BITS),
    .STAT_INIT       (STAT_INIT)
  ) u_table (
    .clk           (clk),
    .rst_n         (rst_n),
    .s1_addr       (s1_addr),
    .update_addr   (update_addr),
    .s1_sp         (s1_sp),
    .s1_lhp        (s1_lhp),
    .s1_ghp        (s1_ghp),
    .resolve_valid (resolve_valid),
    .resolve_taken (resolve_taken),
    .resolve_sp    (resolve_sp),
    .resolve_lhp   (resolve_lhp),
    .resolve_ghp   (resolve_ghp),
    .sp_stat       (sp_stat),
    .lhp_stat      (lhp_stat),
    .ghp_stat      (ghp_stat)
  );

  meta_arbiter #(
    .COUNT_WIDTH (COUNT_WIDTH),
    .STAT_WIDTH  (STAT_WIDTH)
  ) u_arbiter (
    .clk               (clk),
    .rst_n             (rst_n),
    .s1_valid          (s1_valid),
    .s1_sp             (s1_sp),
    .s1_lhp            (s1_lhp),
    .s1_ghp            (s1_ghp),
    .sp_stat           (sp_stat),
    .lhp_stat          (lhp_stat),
    .ghp_stat          (ghp_stat),
    .prediction_valid  (prediction_valid),
    .prediction_taken  (prediction_taken),
    .prediction_source (prediction_source)
  );

endmodule

//--- meta_arbiter.sv
`timescale 1ns/1ps

module meta_arbiter #(
  parameter int COUNT_WIDTH = chooser_pkg::DEFAULT_COUNT_WIDTH,
  parameter int STAT_WIDTH  = chooser_pkg::DEFAULT_STAT_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   s1_valid,
  input  logic                   s1_sp,
  input  logic [COUNT_WIDTH-1:0] s1_lhp,
  input  logic [COUNT_WIDTH-1:0] s1_ghp,
  input  logic [STAT_WIDTH-1:0]  sp_stat,
  input  logic [STAT_WIDTH-1:0]  lhp_stat,
  input  logic [STAT_WIDTH-1:0]  ghp_stat,
  output logic                   prediction_valid,
  output logic                   prediction_taken,
  output chooser_pkg::source_t   prediction_source
);

  import chooser_pkg::*;

  logic    win_taken;
  source_t win_source;

  // Ties go to GHP, then LHP
  always_comb
  begin
    if (ghp_stat >= lhp_stat && ghp_stat >= sp_stat)
    begin
      win_taken  = s1_ghp[COUNT_WIDTH-1];
      win_source = SRC_GHP;
    end
    else if (lhp_stat >= sp_stat)
    begin
      win_taken  = s1_lhp[COUNT_WIDTH-1];
      win_source = SRC_LHP;
    end
    else
    begin
      win_taken  = s1_sp;
      win_source = SRC_SP;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      prediction_valid  <= 1'b0;
      prediction_taken  <= 1'b0;
      prediction_source <= SRC_SP;
    end
    else
    begin
      prediction_valid <= s1_valid;
      if (s1_valid)
      begin
        prediction_taken  <= win_taken;
        prediction_source <= win_source;
      end
    end
  end

endmodule

//--- accuracy_table.sv
`timescale 1ns/1ps

module accuracy_table #(
  parameter int                         COUNT_WIDTH     = chooser_pkg::DEFAULT_COUNT_WIDTH,
  parameter int                         STAT_WIDTH      = chooser_pkg::DEFAULT_STAT_WIDTH,
  parameter int                         STAT_CLEAR_BITS = 2,
  parameter logic [STAT_WIDTH-1:0]      STAT_INIT       = '0
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  branch_pkg::branch_addr_t s1_addr,
  input  branch_pkg::branch_addr_t update_addr,
  input  logic                     s1_sp,
  input  logic [COUNT_WIDTH-1:0]   s1_lhp,
  input  logic [COUNT_WIDTH-1:0]   s1_ghp,
  input  logic                     resolve_valid,
  input  logic                     resolve_taken,
  input  logic                     resolve_sp,
  input  logic [COUNT_WIDTH-1:0]   resolve_lhp,
  input  logic [COUNT_WIDTH-1:0]   resolve_ghp,
  output logic [STAT_WIDTH-1:0]    sp_stat,
  output logic [STAT_WIDTH-1:0]    lhp_stat,
  output logic [STAT_WIDTH-1:0]    ghp_stat
);

  import branch_pkg::*;

  localparam int LOCAL_ENTRIES = 1 << COUNT_WIDTH;

  // Upper bits survive a miss
  localparam logic [STAT_WIDTH-1:0] KEEP_MASK = {STAT_WIDTH{1'b1}} << STAT_CLEAR_BITS;

  logic [STAT_WIDTH-1:0] sp_table  [NUM_BRANCH_TYPES][2];
  logic [STAT_WIDTH-1:0] lhp_table [NUM_BRANCH_TYPES][LOCAL_ENTRIES];
  logic [STAT_WIDTH-1:0] ghp_table [NUM_BRANCH_TYPES][LOCAL_ENTRIES];

  logic                  sp_hit;
  logic                  lhp_hit;
  logic                  ghp_hit;
  logic [STAT_WIDTH-1:0] sp_next;
  logic [STAT_WIDTH-1:0] lhp_next;
  logic [STAT_WIDTH-1:0] ghp_next;
  logic                  sp_fwd;
  logic                  lhp_fwd;
  logic                  ghp_fwd;

  function automatic logic [STAT_WIDTH-1:0] next_stat(input logic [STAT_WIDTH-1:0] cur,
                                                      input logic                  hit);
    logic [STAT_WIDTH-1:0] result;
    if (hit)
    begin
      result = (&cur) ? cur : cur + 1'b1;
    end
    else
    begin
      result = cur & KEEP_MASK;
    end
    return result;
  endfunction

  // Counters predict taken on their MSB
  assign sp_hit  = (resolve_sp == resolve_taken);
  assign lhp_hit = (resolve_lhp[COUNT_WIDTH-1] == resolve_taken);
  assign ghp_hit = (resolve_ghp[COUNT_WIDTH-1] == resolve_taken);

  assign sp_next  = next_stat(sp_table[update_addr][resolve_sp], sp_hit);
  assign lhp_next = next_stat(lhp_table[update_addr][resolve_lhp], lhp_hit);
  assign ghp_next = next_stat(ghp_table[update_addr][resolve_ghp], ghp_hit);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      for (int r = 0; r < NUM_BRANCH_TYPES; r++)
      begin
        sp_table[r][0] <= STAT_INIT;
        sp_table[r][1] <= STAT_INIT;
        for (int e = 0; e < LOCAL_ENTRIES; e++)
        begin
          lhp_table[r][e] <= STAT_INIT;
          ghp_table[r][e] <= STAT_INIT;
        end
      end
    end
    else if (resolve_valid)
    begin
      sp_table[update_addr][resolve_sp]   <= sp_next;
      lhp_table[update_addr][resolve_lhp] <= lhp_next;
      ghp_table[update_addr][resolve_ghp] <= ghp_next;
    end
  end

  // A resolve in the stage 1 cycle still reaches that lookup
  assign sp_fwd  = resolve_valid && (update_addr == s1_addr) && (resolve_sp == s1_sp);
  assign lhp_fwd = resolve_valid && (update_addr == s1_addr) && (resolve_lhp == s1_lhp);
  assign ghp_fwd = resolve_valid && (update_addr == s1_addr) && (resolve_ghp == s1_ghp);

  assign sp_stat  = sp_fwd  ? sp_next  : sp_table[s1_addr][s1_sp];
  assign lhp_stat = lhp_fwd ? lhp_next : lhp_table[s1_addr][s1_lhp];
  assign ghp_stat = ghp_fwd ? ghp_next : ghp_table[s1_addr][s1_ghp];

endmodule

//--- branch_type_decoder.sv
`timescale 1ns/1ps

module branch_type_decoder #(
  parameter int COUNT_WIDTH = chooser_pkg::DEFAULT_COUNT_WIDTH
) (
  input  logic                                              clk,
  input  logic                                              rst_n,
  input  logic                                              lookup_valid,
  input  branch_pkg::branch_onehot_t                        lookup_type,
  input  logic                                              lookup_sp,
  input  logic [COUNT_WIDTH-1:0]                            lookup_ghp,
  input  logic [branch_pkg::NUM_BRANCH_TYPES*COUNT_WIDTH-1:0] lookup_lhp_bank,
  input  branch_pkg::branch_onehot_t                        resolve_type,
  output logic                                              s1_valid,
  output logic                                              s1_sp,
  output branch_pkg::branch_addr_t                          s1_addr,
  output logic [COUNT_WIDTH-1:0]                            s1_ghp,
  output logic [COUNT_WIDTH-1:0]                            s1_lhp,
  output branch_pkg::branch_addr_t                          update_addr
);

  import branch_pkg::*;

  // Row constant for each one-hot bit, index 0 is bgeu
  localparam branch_addr_t ROW_ADDR [NUM_BRANCH_TYPES] = '{
    BGEU_ADDR, BLTU_ADDR, BGE_ADDR, BLT_ADDR, BNE_ADDR, BEQ_ADDR
  };

  branch_addr_t           lookup_addr;
  logic [COUNT_WIDTH-1:0] lookup_lhp;

  // Parallel select, each set bit ORs in its row
  function automatic branch_addr_t type_to_addr(input branch_onehot_t onehot);
    branch_addr_t addr;
    addr = '0;
    for (int i = 0; i < NUM_BRANCH_TYPES; i++)
    begin
      addr = addr | ({$bits(branch_addr_t){onehot[i]}} & ROW_ADDR[i]);
    end
    return addr;
  endfunction

  assign lookup_addr = type_to_addr(lookup_type);
  assign update_addr = type_to_addr(resolve_type);

  // Bank is packed beq highest, so the row number is also the slot
  assign lookup_lhp = lookup_lhp_bank[lookup_addr*COUNT_WIDTH +: COUNT_WIDTH];

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      s1_valid <= 1'b0;
    end
    else
    begin
      s1_valid <= lookup_valid;
    end
  end

  always_ff @(posedge clk)
  begin
    if (lookup_valid)
    begin
      s1_addr <= lookup_addr;
      s1_sp   <= lookup_sp;
      s1_ghp  <= lookup_ghp;
      s1_lhp  <= lookup_lhp;
    end
  end

endmodule

//--- chooser_pkg.sv
package chooser_pkg;

  // Width of the GHP and LHP saturating counters
  localparam int DEFAULT_COUNT_WIDTH = 2;

  // Width of each accuracy counter
  localparam int DEFAULT_STAT_WIDTH = 6;

  // Component that supplied the final prediction
  typedef logic [1:0] source_t;

  localparam source_t SRC_SP  = 2'd0;
  localparam source_t SRC_LHP = 2'd1;
  localparam source_t SRC_GHP = 2'd2;

endpackage

//--- branch_pkg.sv
package branch_pkg;

  // Conditional branch kinds of RV32I
  localparam int NUM_BRANCH_TYPES = 6;

  // One-hot branch type, bit 5 is beq down to bit 0 is bgeu
  typedef logic [NUM_BRANCH_TYPES-1:0] branch_onehot_t;

  // Row of the accuracy tables
  typedef logic [2:0] branch_addr_t;

  localparam branch_addr_t BEQ_ADDR  = 3'd5;
  localparam branch_addr_t BNE_ADDR  = 3'd4;
  localparam branch_addr_t BLT_ADDR  = 3'd3;
  localparam branch_addr_t BGE_ADDR  = 3'd2;
  localparam branch_addr_t BLTU_ADDR = 3'd1;
  localparam branch_addr_t BGEU_ADDR = 3'd0;

endpackage
